/* bootRom.hex */
// One 64-bit doubleword per line, hex, first line at the boot ROM base address
f140257300000297
0202829300000593
0010031380000437
0064202300040413
0000006f10500073
0000000000000013
3402907334001073
3050107330401073
0000000000008067
deadbeefcafef00d
0123456789abcdef
fedcba9876543210
a5a5a5a55a5a5a5a
0f1e2d3c4b5a6978
8000000000001000
ffffffff00000001

/* rtl/ahbDecoder.sv */
// AHB-Lite address decoder that selects a subordinate and steers its data-phase response back
`default_nettype none

module ahbDecoder import uncorePkg::*; (
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic [AddrWidth-1:0] HADDR,
	input  logic                 HREADY,
	input  logic [Xlen-1:0]      HREADTim,
	input  logic                 HREADYTim,
	input  logic                 HRESPTim,
	input  logic [Xlen-1:0]      HREADBootRom,
	input  logic                 HREADYBootRom,
	input  logic                 HRESPBootRom,
	input  logic                 HREADYNone,
	input  logic                 HRESPNone,
	output logic                 HSELTim,
	output logic                 HSELBootRom,
	output logic                 HSELNone,
	output logic [Xlen-1:0]      HRDATA,
	output logic                 HREADYOut,
	output logic                 HRESP
);

	// One-hot owner of the current data phase in the order Tim, BootRom, None
	logic [2:0] dataOwner;

	// Address phase decode where anything outside both windows goes to the error responder
	assign HSELTim     = (HADDR >= TimBase) && (HADDR < TimBase + AddrWidth'(TimRange));
	assign HSELBootRom = (HADDR >= BootRomBase)
		&& (HADDR < BootRomBase + AddrWidth'(BootRomWords * (Xlen / 8)));
	assign HSELNone    = !(HSELTim || HSELBootRom);

	// The address phase turns into a data phase only on an edge where HREADY is high
	// Idle cycles move the owner too, so their one-cycle OKAY comes from the right place
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			// The error responder owns the bus after reset and is ready and OKAY like the others
			dataOwner <= 3'b001;
		end else if (HREADY) begin
			dataOwner <= {HSELTim, HSELBootRom, HSELNone};
		end
	end

	// Response multiplexer for the data phase
	always_comb begin
		case (dataOwner)
			3'b100: begin
				HRDATA    = HREADTim;
				HREADYOut = HREADYTim;
				HRESP     = HRESPTim;
			end
			3'b010: begin
				HRDATA    = HREADBootRom;
				HREADYOut = HREADYBootRom;
				HRESP     = HRESPBootRom;
			end
			default: begin
				// The error responder has no read data
				HRDATA    = '0;
				HREADYOut = HREADYNone;
				HRESP     = HRESPNone;
			end
		endcase
	end

	// Exactly one subordinate is addressed as long as the two windows do not overlap
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$onehot({HSELTim, HSELBootRom, HSELNone}))
		else $error("Decoder selects are not one-hot");

endmodule

`default_nettype wire

/* rtl/bootRom.sv */
// Boot ROM, a zero-wait doubleword read-only memory that answers writes with ERROR
`default_nettype none

module bootRom import uncorePkg::*; (
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic                 HSELBootRom,
	input  logic [AddrWidth-1:0] HADDR,
	input  logic                 HWRITE,
	input  logic                 HREADY,
	input  logic [1:0]           HTRANS,
	output logic [Xlen-1:0]      HREADBootRom,
	output logic                 HREADYBootRom,
	output logic                 HRESPBootRom
);

	// Contents come from the hex image and never change
	logic [Xlen-1:0] romArray [BootRomWords];

	// Address phase accepted on this edge
	logic transStart;

	// The two cycles of the ERROR response to a write
	logic errFirst;
	logic errSecond;

	initial begin
		$readmemh("bootRom.hex", romArray);
	end

	assign transStart = HSELBootRom && HREADY
		&& ((HTRANS == HtransNonseq) || (HTRANS == HtransSeq));

	// The word is registered at the transfer start, so it is there for the single data cycle
	always_ff @(posedge HCLK) begin
		if (transStart && !HWRITE) begin
			HREADBootRom <= romArray[HADDR[3 +: $clog2(BootRomWords)]];
		end
	end

	// Writes are refused with the usual two-cycle ERROR
	// A new transfer may start during the second cycle because ready is back high
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			errFirst  <= 1'b0;
			errSecond <= 1'b0;
		end else begin
			errFirst  <= transStart && HWRITE;
			errSecond <= errFirst;
		end
	end

	assign HREADYBootRom = !errFirst;
	assign HRESPBootRom  = (errFirst || errSecond) ? HrespError : HrespOkay;

	// The first ERROR cycle always gets its closing cycle with ready high
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(HRESPBootRom == HrespError) && !HREADYBootRom
		|=> (HRESPBootRom == HrespError) && HREADYBootRom)
		else $error("Boot ROM ERROR response not completed in the second cycle");

endmodule

`default_nettype wire

/* rtl/dataTim.sv */
// Data TIM that serves doubleword reads and writes on AHB-Lite with one wait state
`default_nettype none

module dataTim import uncorePkg::*; (
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic                 HSELTim,
	input  logic [AddrWidth-1:0] HADDR,
	input  logic                 HWRITE,
	input  logic                 HREADY,
	input  logic [1:0]           HTRANS,
	input  logic [Xlen-1:0]      HWDATA,
	output logic [Xlen-1:0]      HREADTim,
	output logic                 HREADYTim,
	output logic                 HRESPTim
);

	// Doubleword storage indexed by address bit 3 and up
	logic [Xlen-1:0] timArray [TimWords];

	// Address phase accepted on this edge
	logic transStart;

	// Doubleword index and direction captured at the transfer start
	logic [$clog2(TimWords)-1:0] timIndex;
	logic                        writeQ;

	// Wait state in the first data-phase cycle
	logic waitState;

	// Second data-phase cycle that closes the transfer
	logic lastState;

	// Array write strobe on the edge that ends a write data phase
	logic timWrite;

	////////////////////////////////////////////////////////////////////////////
	// Transfer start and wait state
	////////////////////////////////////////////////////////////////////////////

	// IDLE and BUSY never start anything and get the plain one-cycle OKAY
	assign transStart = HSELTim && HREADY
		&& ((HTRANS == HtransNonseq) || (HTRANS == HtransSeq));

	// Two-cycle sequencer that starts once per transfer
	// HREADY is low during the wait state, so a second start cannot slip in
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			waitState <= 1'b0;
			lastState <= 1'b0;
			writeQ    <= 1'b0;
		end else begin
			waitState <= transStart;
			lastState <= waitState;
			// A new transfer may start on the same edge that commits the old write
			if (transStart) begin
				writeQ <= HWRITE;
			end
		end
	end

	// Doubleword index of the open transfer
	always_ff @(posedge HCLK) begin
		if (transStart) begin
			timIndex <= HADDR[3 +: $clog2(TimWords)];
		end
	end

	// Ready drops for exactly the wait state
	assign HREADYTim = !waitState;

	// The TIM never reports an error
	assign HRESPTim = HrespOkay;

	////////////////////////////////////////////////////////////////////////////
	// Memory array
	////////////////////////////////////////////////////////////////////////////

	// HWDATA is valid through the data phase, so the commit waits for its closing edge
	assign timWrite = lastState && writeQ;

	// Read data is fetched at the end of the wait state
	// A write committed on the previous closing edge is already in the array
	always_ff @(posedge HCLK) begin
		if (waitState) begin
			HREADTim <= timArray[timIndex];
		end
		if (timWrite) begin
			timArray[timIndex] <= HWDATA;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// The wait state relies on the decoder feeding back our own low ready
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!HREADYTim |=> HREADYTim)
		else $error("TIM held HREADY low for more than one cycle");

	// Every array write closes a write transfer that started two edges earlier
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		timWrite |-> HREADYTim && $past(transStart && HWRITE, 2))
		else $error("TIM array written outside a write data phase");

endmodule

`default_nettype wire

/* rtl/errorResponder.sv */
// Default subordinate that gives the two-cycle AHB ERROR response for unmapped addresses
`default_nettype none

module errorResponder import uncorePkg::*; (
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       HSELNone,
	input  logic       HREADY,
	input  logic [1:0] HTRANS,
	output logic       HREADYNone,
	output logic       HRESPNone
);

	// Active transfer accepted on this edge
	logic transStart;

	// First ERROR cycle, with ready low
	logic errFirst;

	// Second ERROR cycle, with ready high so the manager can move on
	logic errSecond;

	// IDLE and BUSY fall through to the one-cycle OKAY
	assign transStart = HSELNone && HREADY
		&& (HTRANS != HtransIdle) && (HTRANS != HtransBusy);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			errFirst  <= 1'b0;
			errSecond <= 1'b0;
		end else begin
			// Back-to-back unmapped transfers restart the pair from the top
			errFirst  <= transStart;
			errSecond <= errFirst;
		end
	end

	// Ready stays high everywhere except the first ERROR cycle
	assign HREADYNone = !errFirst;

	// Both cycles of the pair carry ERROR
	assign HRESPNone = (errFirst || errSecond) ? HrespError : HrespOkay;

endmodule

`default_nettype wire

/* rtl/uncore.sv */
// Memory-side uncore that joins the AHB-Lite decoder with the TIM, boot ROM and error responder
`default_nettype none

module uncore import uncorePkg::*; (
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic [AddrWidth-1:0] HADDR,
	input  logic                 HWRITE,
	input  logic [1:0]           HTRANS,
	input  logic [Xlen-1:0]      HWDATA,
	output logic [Xlen-1:0]      HRDATA,
	output logic                 HREADY,
	output logic                 HRESP
);

	// Subordinate selects from the decoder
	logic HSELTim;
	logic HSELBootRom;
	logic HSELNone;

	// Per-subordinate responses, multiplexed by the decoder
	logic [Xlen-1:0] HREADTim;
	logic            HREADYTim;
	logic            HRESPTim;
	logic [Xlen-1:0] HREADBootRom;
	logic            HREADYBootRom;
	logic            HRESPBootRom;
	logic            HREADYNone;
	logic            HRESPNone;

	////////////////////////////////////////////////////////////////////////////
	// Decoder
	////////////////////////////////////////////////////////////////////////////

	// The multiplexed HREADY leaves the uncore and also comes back to every block
	ahbDecoder i_decoder (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.HADDR        (HADDR),
		.HREADY       (HREADY),
		.HREADTim     (HREADTim),
		.HREADYTim    (HREADYTim),
		.HRESPTim     (HRESPTim),
		.HREADBootRom (HREADBootRom),
		.HREADYBootRom(HREADYBootRom),
		.HRESPBootRom (HRESPBootRom),
		.HREADYNone   (HREADYNone),
		.HRESPNone    (HRESPNone),
		.HSELTim      (HSELTim),
		.HSELBootRom  (HSELBootRom),
		.HSELNone     (HSELNone),
		.HRDATA       (HRDATA),
		.HREADYOut    (HREADY),
		.HRESP        (HRESP)
	);

	////////////////////////////////////////////////////////////////////////////
	// Subordinates
	////////////////////////////////////////////////////////////////////////////

	dataTim i_dataTim (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.HSELTim  (HSELTim),
		.HADDR    (HADDR),
		.HWRITE   (HWRITE),
		.HREADY   (HREADY),
		.HTRANS   (HTRANS),
		.HWDATA   (HWDATA),
		.HREADTim (HREADTim),
		.HREADYTim(HREADYTim),
		.HRESPTim (HRESPTim)
	);

	// Read-only, so no write data goes here
	bootRom i_bootRom (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.HSELBootRom  (HSELBootRom),
		.HADDR        (HADDR),
		.HWRITE       (HWRITE),
		.HREADY       (HREADY),
		.HTRANS       (HTRANS),
		.HREADBootRom (HREADBootRom),
		.HREADYBootRom(HREADYBootRom),
		.HRESPBootRom (HRESPBootRom)
	);

	errorResponder i_errorResponder (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELNone  (HSELNone),
		.HREADY    (HREADY),
		.HTRANS    (HTRANS),
		.HREADYNone(HREADYNone),
		.HRESPNone (HRESPNone)
	);

endmodule

`default_nettype wire

/* rtl/uncorePkg.sv */
// Uncore package with the bus widths, the address map and the AHB-Lite transfer codes
`default_nettype none

package uncorePkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////

	// Data bus width, and every transfer moves one whole doubleword
	localparam int Xlen = 64;

	// Byte address width of the manager port
	localparam int AddrWidth = 32;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////////////

	// Data TIM window, 64 KiB starting at the top half of the address space
	localparam logic [AddrWidth-1:0] TimBase = 32'h8000_0000;
	localparam int TimRange = 65536;

	// TIM depth in doublewords
	localparam int TimWords = TimRange / (Xlen / 8);

	// Boot ROM window, sixteen doublewords just above the first page
	localparam logic [AddrWidth-1:0] BootRomBase = 32'h0000_1000;
	localparam int BootRomWords = 16;

	////////////////////////////////////////////////////////////////////////////
	// AHB-Lite codes
	////////////////////////////////////////////////////////////////////////////

	// HTRANS encodings, only NONSEQ and SEQ start a real transfer
	localparam logic [1:0] HtransIdle   = 2'b00;
	localparam logic [1:0] HtransBusy   = 2'b01;
	localparam logic [1:0] HtransNonseq = 2'b10;
	localparam logic [1:0] HtransSeq    = 2'b11;

	// HRESP encodings
	localparam logic HrespOkay  = 1'b0;
	localparam logic HrespError = 1'b1;

endpackage

`default_nettype wire

/* sim.f */
rtl/uncorePkg.sv
rtl/ahbDecoder.sv
rtl/dataTim.sv
rtl/bootRom.sv
rtl/errorResponder.sv
rtl/uncore.sv
testbench/uncoreTb.sv

/* testbench/uncoreTb.sv */
// Testbench for the uncore that drives pipelined AHB-Lite transfers and checks them against a model
`default_nettype none

module uncoreTb import uncorePkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	logic                 HCLK = 1'b0;
	logic                 HRESETn;
	logic [AddrWidth-1:0] HADDR;
	logic                 HWRITE;
	logic [1:0]           HTRANS;
	logic [Xlen-1:0]      HWDATA;
	logic [Xlen-1:0]      HRDATA;
	logic                 HREADY;
	logic                 HRESP;

	// Reference contents of both memories
	logic [Xlen-1:0] refTim [TimWords];
	logic [Xlen-1:0] romRef [BootRomWords];

	// Addresses reused by the read-back passes
	logic [AddrWidth-1:0] timAddr [200];
	logic [AddrWidth-1:0] mixAddr [16];

	// Expected shape of the data phase that is on the bus now
	int                          dpCycle = 1;
	int                          dpLen = 1;
	logic                        dpResp = HrespOkay;
	logic                        dpRead = 1'b0;
	logic                        dpTimWrite = 1'b0;
	logic [$clog2(TimWords)-1:0] dpIndex = '0;
	logic [Xlen-1:0]             dpData = '0;

	logic [31:0] lfsrState = 32'h5549533e;
	int          cycleCount = 0;
	int          issuedCycles = 0;

	uncore i_dut (
		.HCLK   (HCLK),
		.HRESETn(HRESETn),
		.HADDR  (HADDR),
		.HWRITE (HWRITE),
		.HTRANS (HTRANS),
		.HWDATA (HWDATA),
		.HRDATA (HRDATA),
		.HREADY (HREADY),
		.HRESP  (HRESP)
	);

	always #50 HCLK = ~HCLK;

	////////////////////////////////////////////////////////////////////////////
	// Address map and response rules
	////////////////////////////////////////////////////////////////////////////

	function automatic logic inTim(input logic [AddrWidth-1:0] addr);
		return (addr >= TimBase) && (addr < TimBase + TimRange);
	endfunction

	function automatic logic inBootRom(input logic [AddrWidth-1:0] addr);
		return (addr >= BootRomBase) && (addr < BootRomBase + BootRomWords * 8);
	endfunction

	function automatic logic transActive(input logic [1:0] trans);
		return (trans == HtransNonseq) || (trans == HtransSeq);
	endfunction

	// Only boot ROM reads and idle cycles finish in one cycle
	function automatic int phaseLength(input logic [AddrWidth-1:0] addr, input logic write,
			input logic [1:0] trans);
		if (!transActive(trans) || (inBootRom(addr) && !write)) begin
			return 1;
		end
		return 2;
	endfunction

	// ERROR for unmapped addresses and for writes into the ROM
	function automatic logic phaseResp(input logic [AddrWidth-1:0] addr, input logic write,
			input logic [1:0] trans);
		if (transActive(trans) && !inTim(addr) && (write || !inBootRom(addr))) begin
			return HrespError;
		end
		return HrespOkay;
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
	function automatic logic [Xlen-1:0] randomBits(input int count);
		logic [Xlen-1:0] value;
		logic            feedback;
		value = '0;
		for (int n = 0; n < count; n++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[Xlen-2:0], feedback};
		end
		return value;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Model and checks
	////////////////////////////////////////////////////////////////////////////

	// A data phase ends on the edge where the model says it is complete
	always @(posedge HCLK) begin
		if (!HRESETn) begin
			dpCycle    <= 1;
			dpLen      <= 1;
			dpResp     <= HrespOkay;
			dpRead     <= 1'b0;
			dpTimWrite <= 1'b0;
		end else if (dpCycle >= dpLen) begin
			if (dpTimWrite) begin
				refTim[dpIndex] <= HWDATA;
			end
			dpCycle    <= 1;
			dpLen      <= phaseLength(HADDR, HWRITE, HTRANS);
			dpResp     <= phaseResp(HADDR, HWRITE, HTRANS);
			dpRead     <= transActive(HTRANS) && !HWRITE && (inTim(HADDR) || inBootRom(HADDR));
			dpTimWrite <= transActive(HTRANS) && HWRITE && inTim(HADDR);
			dpIndex    <= HADDR[3 +: $clog2(TimWords)];
			// A read right behind a write to the same word sees the new data
			if (!inTim(HADDR)) begin
				dpData <= romRef[HADDR[3 +: $clog2(BootRomWords)]];
			end else if (dpTimWrite && (dpIndex == HADDR[3 +: $clog2(TimWords)])) begin
				dpData <= HWDATA;
			end else begin
				dpData <= refTim[HADDR[3 +: $clog2(TimWords)]];
			end
		end else begin
			dpCycle <= dpCycle + 1;
		end
	end

	task automatic reportMismatch(input string name, input logic [Xlen-1:0] expected,
			input logic [Xlen-1:0] actual);
		$display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	// Ready is high only in the last cycle of a data phase, also in reset
	assert property (@(posedge HCLK) HREADY == (dpCycle >= dpLen))
		else reportMismatch("HREADY", $sampled(dpCycle >= dpLen), $sampled(HREADY));

	assert property (@(posedge HCLK) HRESP == dpResp)
		else reportMismatch("HRESP", $sampled(dpResp), $sampled(HRESP));

	assert property (@(posedge HCLK) dpRead && (dpCycle >= dpLen) |-> HRDATA == dpData)
		else reportMismatch("HRDATA", $sampled(dpData), $sampled(HRDATA));

	// Every issued cycle may take twice as long before the run counts as hung
	always @(posedge HCLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > 2 * issuedCycles + 50) begin
			$display("The test timed out after %0d cycles with no bus progress", cycleCount);
			$display("TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Manager
	////////////////////////////////////////////////////////////////////////////

	// Entered on a falling edge, returns on the falling edge after the address is taken
	// HREADY is stable in the second half of the cycle, so it is read there
	task automatic busTransfer(input logic [AddrWidth-1:0] addr, input logic write,
			input logic [1:0] trans, input logic [Xlen-1:0] wdata);
		logic accepted;
		HADDR = addr;
		HWRITE = write;
		HTRANS = trans;
		issuedCycles += phaseLength(addr, write, trans);
		accepted = 1'b0;
		while (!accepted) begin
			accepted = HREADY;
			@(negedge HCLK);
		end
		HWDATA = wdata;
	endtask

	initial begin
		HADDR = '0;
		HWRITE = 1'b0;
		HTRANS = HtransIdle;
		HWDATA = '0;
		// Start released so the asynchronous reset sees a clean falling edge
		HRESETn = 1'b1;
		$readmemh("bootRom.hex", romRef);
		#1 HRESETn = 1'b0;
		repeat (5) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;

		// Random TIM writes, then reads of the same words
		for (int i = 0; i < 200; i++) begin
			timAddr[i] = TimBase + (AddrWidth'(randomBits($clog2(TimWords))) << 3);
			busTransfer(timAddr[i], 1'b1, HtransNonseq, randomBits(Xlen));
		end
		for (int i = 0; i < 200; i++) begin
			busTransfer(timAddr[i], 1'b0, (i % 2) ? HtransSeq : HtransNonseq, randomBits(Xlen));
		end

		// Whole boot ROM back to back
		for (int i = 0; i < BootRomWords; i++) begin
			busTransfer(BootRomBase + AddrWidth'(i * 8), 1'b0, HtransNonseq, '0);
		end

		// Refused ROM write, then the same word still holds its image
		busTransfer(BootRomBase + 32'h28, 1'b1, HtransNonseq, randomBits(Xlen));
		busTransfer(BootRomBase + 32'h28, 1'b0, HtransNonseq, '0);

		// Just outside each window, and somewhere far away
		busTransfer(BootRomBase + BootRomWords * 8, 1'b0, HtransNonseq, '0);
		busTransfer(TimBase - 32'h8, 1'b1, HtransNonseq, randomBits(Xlen));
		busTransfer(TimBase + TimRange, 1'b0, HtransNonseq, '0);
		busTransfer(32'h4000_0100, 1'b1, HtransNonseq, randomBits(Xlen));

		// Mixed rounds where IDLE and BUSY carry a write to the same TIM word
		for (int i = 0; i < 16; i++) begin
			mixAddr[i] = TimBase + (AddrWidth'(randomBits($clog2(TimWords))) << 3);
			busTransfer(mixAddr[i], 1'b1, HtransNonseq, randomBits(Xlen));
			busTransfer(mixAddr[i], 1'b0, HtransSeq, randomBits(Xlen));
			busTransfer(mixAddr[i], 1'b1, HtransIdle, randomBits(Xlen));
			busTransfer(BootRomBase + AddrWidth'(i * 8), 1'b0, HtransNonseq, '0);
			busTransfer(mixAddr[i], 1'b1, HtransBusy, randomBits(Xlen));
		end
		for (int i = 0; i < 16; i++) begin
			busTransfer(mixAddr[i], 1'b0, HtransNonseq, '0);
		end

		// Closing idle lets the last data phase finish under the checks
		busTransfer('0, 1'b0, HtransIdle, '0);
		@(negedge HCLK);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
